/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_wb_top
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "RESULT: FAIL" $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* gpr_file.sv */
// general registers with three sized write ports, eip and cs registers
`default_nettype none

`include "wb_settings.svh"

module gpr_file (
   input  logic                           CLK,
   input  logic                           rst_n,
   input  wb_pkg::commit_t                commit,
   input  logic [$clog2(`WB_NUM_GPR)-1:0] rd_idx,
   output logic [31:0]                    rd_data,
   output logic [31:0]                    eip,
   output logic [15:0]                    cs
);

   logic [31:0] regs [`WB_NUM_GPR];

   // byte and word writes keep the upper part of the register
   function automatic logic [31:0] merge_sized(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input wb_pkg::datasize_e size);
      case (size)
         wb_pkg::DS_BYTE: return {old_val[31:8], new_val[7:0]};
         wb_pkg::DS_WORD: return {old_val[31:16], new_val[15:0]};
         default:         return new_val;
      endcase
   endfunction

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int i = 0; i < `WB_NUM_GPR; i++) begin
            regs[i] <= '0;
         end
         eip <= '0;
         cs  <= '0;
      end else begin
         // later ports override earlier ones on the same index
         if (commit.ld_gpr1) begin
            regs[commit.dr1] <= merge_sized(regs[commit.dr1], commit.data1, commit.datasize);
         end
         if (commit.ld_gpr2) begin
            regs[commit.dr2] <= merge_sized(regs[commit.dr2], commit.data2, commit.datasize);
         end
         if (commit.ld_gpr3) begin
            regs[commit.dr3] <= merge_sized(regs[commit.dr3], commit.data3, commit.datasize);
         end
         if (commit.ld_eip) begin
            eip <= commit.eip;
         end
         if (commit.ld_cs) begin
            cs <= commit.cs;
         end
      end
   end

   assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

/* tb_wb_top.sv */
// directed testbench for wb_top with clock, reset, wishbone slave model, tests and watchdog
`default_nettype none

`include "wb_settings.svh"

module tb_wb_top;

   timeunit 1ns;
   timeprecision 1ns;

   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 2000;

   logic           CLK;
   logic           rst_n;
   wb_pkg::uop_t   uop_in;
   logic           stall;
   logic           wb_cyc;
   logic           wb_stb;
   logic           wb_we;
   logic [31:0]    wb_adr;
   logic [31:0]    wb_dat_w;
   logic [3:0]     wb_sel;
   logic           wb_ack;
   logic [2:0]     rd_idx;
   logic [31:0]    rd_data;
   logic [31:0]    eip;
   logic [15:0]    cs;
   wb_pkg::flags_u flags;
   logic           halted;
   logic           repne_term;

   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;
   int unsigned wait_left;
   logic        in_cycle;
   logic [31:0] store_adr_log[$];
   logic [31:0] store_dat_log[$];

   wb_top i_wb_top (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .uop_in     (uop_in),
      .stall      (stall),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .wb_ack     (wb_ack),
      .rd_idx     (rd_idx),
      .rd_data    (rd_data),
      .eip        (eip),
      .cs         (cs),
      .flags      (flags),
      .halted     (halted),
      .repne_term (repne_term)
   );

   bind wb_top wb_asserts u_wb_asserts (.*);

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   // wishbone slave with 0 to 3 extra wait states per store
   initial begin
      void'($urandom(27));
      wb_ack = 1'b0;
      in_cycle = 1'b0;
      wait_left = 0;
      forever begin
         @(posedge CLK);
         if (!rst_n) begin
            wb_ack <= 1'b0;
            in_cycle = 1'b0;
         end else if (wb_ack) begin
            wb_ack <= 1'b0;
            in_cycle = 1'b0;
            store_adr_log.push_back(wb_adr);
            store_dat_log.push_back(wb_dat_w);
            check_val("wb_sel", {28'h0, wb_sel}, 32'h0000_000f);
            check_bit("wb_we", wb_we, 1'b1);
         end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
               in_cycle = 1'b1;
               wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
               wb_ack <= 1'b1;
            end else begin
               wait_left--;
            end
         end
      end
   end

   function automatic void check_val(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endfunction

   function automatic void check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endfunction

   function automatic void check_store(input logic [31:0] exp_adr, input logic [31:0] exp_dat);
      assert (store_adr_log.size() != 0) else begin
         $display("at %0t ns a store to %h was expected but the slave logged none",
                  $time, exp_adr);
         errors++;
      end
      if (store_adr_log.size() != 0) begin
         check_val("store wb_adr", store_adr_log.pop_front(), exp_adr);
         check_val("store wb_dat_w", store_dat_log.pop_front(), exp_dat);
      end
   endfunction

   // all control bits clear and dword size
   function automatic wb_pkg::uop_t new_uop();
      wb_pkg::uop_t u;
      u = '0;
      u.valid = 1'b1;
      u.datasize = wb_pkg::DS_DWORD;
      return u;
   endfunction

   task automatic apply_reset();
      @(posedge CLK);
      rst_n <= 1'b0;
      uop_in <= '0;
      repeat (16) @(posedge CLK);
      rst_n <= 1'b1;
   endtask

   // present a uop and hold it until the edge that accepts it
   task automatic send_uop(input wb_pkg::uop_t u);
      @(posedge CLK);
      uop_in <= u;
      @(negedge CLK);
      while (stall) begin
         @(negedge CLK);
      end
      @(posedge CLK);
      uop_in <= '0;
   endtask

   // returns at the negedge after the stage has retired its uop
   task automatic wait_retire();
      @(negedge CLK);
      while (stall) begin
         @(negedge CLK);
      end
      @(posedge CLK);
      @(negedge CLK);
   endtask

   task automatic issue(input wb_pkg::uop_t u);
      send_uop(u);
      wait_retire();
   endtask

   task automatic set_flags(input logic [31:0] value);
      wb_pkg::uop_t u;
      u = new_uop();
      u.ld_flags = 1'b1;
      u.flags_affected = '1;
      u.new_flags.raw = value;
      issue(u);
   endtask

   task automatic check_reg(input logic [2:0] idx, input logic [31:0] exp);
      @(posedge CLK);
      rd_idx <= idx;
      @(negedge CLK);
      check_val($sformatf("rd_data[%0d]", idx), rd_data, exp);
   endtask

   task automatic begin_test();
      errors_at_start = errors;
      store_adr_log.delete();
      store_dat_log.delete();
      apply_reset();
   endtask

   function automatic void end_test(input string name);
      assert (store_adr_log.size() == 0) else begin
         $display("at %0t ns the slave logged %0d stores that no check expected",
                  $time, store_adr_log.size());
         errors++;
      end
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d checks failed", name, errors - errors_at_start);
      end
   endfunction

   task automatic sized_writes_test();
      wb_pkg::uop_t u;
      begin_test();
      u = new_uop();
      u.ld_gpr1 = 1'b1;
      u.dr1 = 3'd1;
      u.result_a = 32'h1122_3344;
      u.ld_gpr2 = 1'b1;
      u.dr2 = 3'd2;
      u.result_b = 32'h5566_7788;
      u.ld_gpr3 = 1'b1;
      u.dr3 = 3'd3;
      u.result_c = 32'h99aa_bbcc;
      issue(u);
      // byte writes keep bits 31:8
      u.ld_gpr3 = 1'b0;
      u.datasize = wb_pkg::DS_BYTE;
      u.result_a = 32'hffff_ffaa;
      u.result_b = 32'hffff_ffbb;
      issue(u);
      u = new_uop();
      u.datasize = wb_pkg::DS_WORD;
      u.ld_gpr3 = 1'b1;
      u.dr3 = 3'd3;
      u.result_c = 32'hffff_1234;
      issue(u);
      check_reg(3'd1, 32'h1122_33aa);
      check_reg(3'd2, 32'h5566_77bb);
      check_reg(3'd3, 32'h99aa_1234);
      // same index on all ports and then on ports 1 and 2
      u = new_uop();
      u.ld_gpr1 = 1'b1;
      u.ld_gpr2 = 1'b1;
      u.ld_gpr3 = 1'b1;
      u.dr1 = 3'd4;
      u.dr2 = 3'd4;
      u.dr3 = 3'd4;
      u.result_a = 32'h0000_0001;
      u.result_b = 32'h0000_0002;
      u.result_c = 32'h0000_0003;
      issue(u);
      u.ld_gpr3 = 1'b0;
      u.dr1 = 3'd5;
      u.dr2 = 3'd5;
      issue(u);
      check_reg(3'd4, 32'h0000_0003);
      check_reg(3'd5, 32'h0000_0002);
      end_test("sized writes");
   endtask

   task automatic flags_test();
      wb_pkg::uop_t u;
      begin_test();
      u = new_uop();
      u.ld_flags = 1'b1;
      u.flags_affected = (1 << `WB_CF_BIT) | (1 << `WB_ZF_BIT) | (1 << `WB_SF_BIT);
      u.new_flags.raw = '1;
      issue(u);
      check_val("flags", flags.raw, 32'h0000_00c1);
      u.flags_affected = (1 << `WB_SF_BIT) | (1 << `WB_OF_BIT);
      u.new_flags.raw = ~(32'd1 << `WB_SF_BIT);
      issue(u);
      check_val("flags", flags.raw, 32'h0000_0841);
      check_bit("flags.zf", flags.bits.zf, 1'b1);
      check_bit("flags.sf", flags.bits.sf, 1'b0);
      // popf
      u = new_uop();
      u.pop_flags = 1'b1;
      u.result_a = 32'h0000_0c04;
      issue(u);
      check_val("flags", flags.raw, 32'h0000_0c04);
      // pushf
      u = new_uop();
      u.push_flags = 1'b1;
      u.dcache_write = 1'b1;
      u.address = 32'h0000_1000;
      issue(u);
      check_store(32'h0000_1000, 32'h0000_0c04);
      end_test("flags");
   endtask

   task automatic cond_commit_test();
      wb_pkg::uop_t u;
      begin_test();
      set_flags(32'd1 << `WB_ZF_BIT);
      u = new_uop();
      u.is_jne = 1'b1;
      u.neip = 32'h0000_0100;
      issue(u);
      check_val("eip", eip, 32'h0000_0000);
      set_flags(32'd0);
      u.neip = 32'h0000_0200;
      issue(u);
      check_val("eip", eip, 32'h0000_0200);
      // the condition sees the flags before this uop's own update
      u.neip = 32'h0000_0280;
      u.ld_flags = 1'b1;
      u.flags_affected = 32'd1 << `WB_ZF_BIT;
      u.new_flags.raw = '1;
      issue(u);
      check_val("eip", eip, 32'h0000_0280);
      check_bit("flags.zf", flags.bits.zf, 1'b1);
      set_flags(32'd1 << `WB_CF_BIT);
      u = new_uop();
      u.is_jnbe = 1'b1;
      u.neip = 32'h0000_0300;
      issue(u);
      check_val("eip", eip, 32'h0000_0280);
      set_flags(32'd1 << `WB_ZF_BIT);
      u.neip = 32'h0000_0380;
      issue(u);
      check_val("eip", eip, 32'h0000_0280);
      set_flags(32'd0);
      u.neip = 32'h0000_0400;
      issue(u);
      check_val("eip", eip, 32'h0000_0400);
      // cmovc with carry clear and then set
      u = new_uop();
      u.is_cmovc = 1'b1;
      u.dr2 = 3'd6;
      u.result_b = 32'hcafe_0001;
      issue(u);
      check_reg(3'd6, 32'h0000_0000);
      set_flags(32'd1 << `WB_CF_BIT);
      u.result_b = 32'hdead_beef;
      issue(u);
      check_reg(3'd6, 32'hdead_beef);
      u = new_uop();
      u.ld_cs = 1'b1;
      u.ncs = 16'h001b;
      issue(u);
      check_val("cs", {16'h0, cs}, 32'h0000_001b);
      end_test("conditional commits");
   endtask

   task automatic store_test();
      wb_pkg::uop_t u;
      begin_test();
      for (int i = 0; i < 6; i++) begin
         u = new_uop();
         u.dcache_write = 1'b1;
         u.address = 32'h0000_2000 + i * 4;
         u.result_a = 32'ha500_0000 + i * 32'h0101_0101;
         send_uop(u);
      end
      wait_retire();
      for (int i = 0; i < 6; i++) begin
         check_store(32'h0000_2000 + i * 4, 32'ha500_0000 + i * 32'h0101_0101);
      end
      // alu uop held behind a store
      check_reg(3'd7, 32'h0000_0000);
      u = new_uop();
      u.dcache_write = 1'b1;
      u.address = 32'h0000_3000;
      u.result_a = 32'h1357_9bdf;
      send_uop(u);
      u = new_uop();
      u.ld_gpr1 = 1'b1;
      u.dr1 = 3'd7;
      u.result_a = 32'h0000_7777;
      @(posedge CLK);
      uop_in <= u;
      @(negedge CLK);
      while (stall) begin
         check_val("rd_data[7]", rd_data, 32'h0000_0000);
         @(negedge CLK);
      end
      @(posedge CLK);
      uop_in <= '0;
      @(negedge CLK);
      check_val("rd_data[7]", rd_data, 32'h0000_0000);
      check_store(32'h0000_3000, 32'h1357_9bdf);
      @(posedge CLK);
      @(negedge CLK);
      check_val("rd_data[7]", rd_data, 32'h0000_7777);
      end_test("store back-pressure");
   endtask

   task automatic repne_case(input logic zf_set, input logic [31:0] count,
                             input logic [31:0] target, input logic exp_term,
                             input logic [31:0] exp_eip);
      wb_pkg::uop_t u;
      set_flags(zf_set ? (32'd1 << `WB_ZF_BIT) : 32'd0);
      u = new_uop();
      u.is_cmps_second = 1'b1;
      u.repne = 1'b1;
      u.ld_eip = 1'b1;
      u.neip = target;
      u.result_c = count;
      send_uop(u);
      @(negedge CLK);
      check_bit("repne_term", repne_term, exp_term);
      @(posedge CLK);
      @(negedge CLK);
      check_val("eip", eip, exp_eip);
   endtask

   task automatic repne_test();
      begin_test();
      repne_case(1'b0, 32'd0, 32'h0000_0700, 1'b1, 32'h0000_0700);
      repne_case(1'b1, 32'd5, 32'h0000_0800, 1'b1, 32'h0000_0800);
      // no match and count left so the loop repeats
      repne_case(1'b0, 32'd5, 32'h0000_0900, 1'b0, 32'h0000_0800);
      end_test("repne cmps");
   endtask

   task automatic halt_test();
      wb_pkg::uop_t u;
      wb_pkg::uop_t h;
      begin_test();
      u = new_uop();
      u.ld_gpr1 = 1'b1;
      u.dr1 = 3'd1;
      u.result_a = 32'h0000_1111;
      issue(u);
      h = new_uop();
      h.is_halt = 1'b1;
      send_uop(h);
      u.result_a = 32'h0000_2222;
      u.ld_eip = 1'b1;
      u.neip = 32'h0000_5000;
      @(posedge CLK);
      uop_in <= u;
      repeat (20) begin
         @(negedge CLK);
         check_bit("stall", stall, 1'b1);
      end
      check_bit("halted", halted, 1'b1);
      @(posedge CLK);
      uop_in <= '0;
      check_reg(3'd1, 32'h0000_1111);
      check_val("eip", eip, 32'h0000_0000);
      apply_reset();
      @(negedge CLK);
      check_bit("halted", halted, 1'b0);
      check_bit("stall", stall, 1'b0);
      issue(u);
      check_reg(3'd1, 32'h0000_2222);
      check_val("eip", eip, 32'h0000_5000);
      end_test("halt");
   endtask

   initial begin
      repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge CLK);
      $display("timeout: tests did not finish within %0d cycles",
               NUM_TESTS * CYCLES_PER_TEST);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      uop_in = '0;
      rd_idx = 3'd0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      sized_writes_test();
      flags_test();
      cond_commit_test();
      store_test();
      repne_test();
      halt_test();
      if (i_wb_top.u_wb_asserts.fail_count != 0) begin
         $display("%0d bound assertion failures occurred during the run",
                  i_wb_top.u_wb_asserts.fail_count);
         errors += i_wb_top.u_wb_asserts.fail_count;
      end
      $display("tests run %0d, tests failed %0d, checks failed %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
wb_pkg.sv
wb_flags_reg.sv
wb_commit_ctrl.sv
wb_stage.sv
wb_store_port.sv
gpr_file.sv
wb_top.sv
wb_asserts.sv
tb_wb_top.sv

/* wb_asserts.sv */
// concurrent checks on the wishbone handshake and the stall output
`default_nettype none

module wb_asserts (
   input logic        CLK,
   input logic        rst_n,
   input logic        wb_cyc,
   input logic        wb_stb,
   input logic        wb_ack,
   input logic [31:0] wb_adr,
   input logic [31:0] wb_dat_w,
   input logic        stall
);

   timeunit 1ns;
   timeprecision 1ns;

   int fail_count = 0;

   stb_within_cyc: assert property (@(posedge CLK) disable iff (!rst_n) wb_stb |-> wb_cyc)
      else begin
         $error("wb_stb high without wb_cyc");
         fail_count++;
      end

   // address and data held while waiting for ack
   req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
      (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w)))
      else begin
         $error("wb_adr or wb_dat_w changed before ack");
         fail_count++;
      end

   stall_after_reset: assert property (@(posedge CLK) $rose(rst_n) |-> !stall)
      else begin
         $error("stall high in the first cycle after reset");
         fail_count++;
      end

endmodule

`default_nettype wire

/* wb_commit_ctrl.sv */
// commit control: validated enables, conditional eip/gpr2 loads, repne exit, halt
`default_nettype none

module wb_commit_ctrl (
   input  wb_pkg::uop_t   uop,
   input  wb_pkg::flags_u flags,
   output logic           ld_gpr1,
   output logic           ld_gpr2,
   output logic           ld_gpr3,
   output logic           ld_eip,
   output logic           ld_cs,
   output logic           ld_flags,
   output logic           pop,
   output logic           store,
   output logic           halt,
   output logic           repne_term
);

   logic cf;
   logic zf;
   logic cmps_exit;
   logic eip_cond;
   logic gpr2_cond;

   // flags as they stood before this uop
   assign cf = flags.bits.cf;
   assign zf = flags.bits.zf;

   // leave the repne loop on a match or an exhausted count
   assign cmps_exit = zf | (uop.result_c == 32'd0);

   always_comb begin
      if (uop.is_cmps_second && uop.repne) begin
         eip_cond = cmps_exit;
      end else if (uop.is_jne) begin
         eip_cond = ~zf;
      end else if (uop.is_jnbe) begin
         eip_cond = ~cf & ~zf;
      end else begin
         eip_cond = uop.ld_eip;
      end
   end

   // cmovc only writes its destination on carry
   assign gpr2_cond = uop.is_cmovc ? cf : uop.ld_gpr2;

   assign ld_gpr1    = uop.valid & uop.ld_gpr1;
   assign ld_gpr2    = uop.valid & gpr2_cond;
   assign ld_gpr3    = uop.valid & uop.ld_gpr3;
   assign ld_eip     = uop.valid & eip_cond;
   assign ld_cs      = uop.valid & uop.ld_cs;
   assign ld_flags   = uop.valid & uop.ld_flags;
   assign pop        = uop.valid & uop.pop_flags;
   assign store      = uop.valid & uop.dcache_write;
   assign halt       = uop.valid & uop.is_halt;
   assign repne_term = uop.valid & uop.is_cmps_second & uop.repne & cmps_exit;

endmodule

`default_nettype wire

/* wb_flags_reg.sv */
// architectural flags register with masked update and popf load
`default_nettype none

module wb_flags_reg (
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           upd,
   input  logic           pop,
   input  logic [31:0]    mask,
   input  wb_pkg::flags_u new_flags,
   input  logic [31:0]    pop_word,
   output wb_pkg::flags_u flags
);

   logic [31:0] merged;

   // only bits named in the mask take the new value
   assign merged = (flags.raw & ~mask) | (new_flags.raw & mask);

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         flags.raw <= '0;
      end else if (pop) begin
         // popf replaces the whole word
         flags.raw <= pop_word;
      end else if (upd) begin
         flags.raw <= merged;
      end
   end

endmodule

`default_nettype wire

/* wb_pkg.sv */
// package with flags union, micro-op and commit structs, operand size enum
`default_nettype none

`include "wb_settings.svh"

package wb_pkg;

   typedef enum logic [1:0] {
      DS_BYTE  = 2'd0,
      DS_WORD  = 2'd1,
      DS_DWORD = 2'd2
   } datasize_e;

   // named view of the flags, filler widths follow the bit positions
   typedef struct packed {
      logic [31-`WB_OF_BIT-1:0]           rsvd_hi;
      logic                               of;
      logic                               df;
      logic [`WB_DF_BIT-`WB_SF_BIT-2:0]   rsvd_9_8;
      logic                               sf;
      logic                               zf;
      logic [`WB_ZF_BIT-`WB_AF_BIT-2:0]   rsvd_5;
      logic                               af;
      logic [`WB_AF_BIT-`WB_PF_BIT-2:0]   rsvd_3;
      logic                               pf;
      logic [`WB_PF_BIT-`WB_CF_BIT-2:0]   rsvd_1;
      logic                               cf;
   } flag_bits_t;

   // raw word for pushf/popf, bits for the condition checks
   typedef union packed {
      logic [31:0] raw;
      flag_bits_t  bits;
   } flags_u;

   typedef struct packed {
      logic                            valid;
      logic [31:0]                     neip;
      logic [15:0]                     ncs;
      logic [31:0]                     result_a;
      logic [31:0]                     result_b;
      logic [31:0]                     result_c;
      flags_u                          new_flags;
      logic [$clog2(`WB_NUM_GPR)-1:0]  dr1;
      logic [$clog2(`WB_NUM_GPR)-1:0]  dr2;
      logic [$clog2(`WB_NUM_GPR)-1:0]  dr3;
      datasize_e                       datasize;
      logic [31:0]                     address;
      // decoded control bits
      logic                            ld_gpr1;
      logic                            ld_gpr2;
      logic                            ld_gpr3;
      logic                            ld_flags;
      logic [31:0]                     flags_affected;
      logic                            pop_flags;
      logic                            push_flags;
      logic                            ld_eip;
      logic                            is_jne;
      logic                            is_jnbe;
      logic                            is_cmovc;
      logic                            ld_cs;
      logic                            dcache_write;
      logic                            is_cmps_second;
      logic                            repne;
      logic                            is_halt;
   } uop_t;

   typedef struct packed {
      logic                            ld_gpr1;
      logic [$clog2(`WB_NUM_GPR)-1:0]  dr1;
      logic [31:0]                     data1;
      logic                            ld_gpr2;
      logic [$clog2(`WB_NUM_GPR)-1:0]  dr2;
      logic [31:0]                     data2;
      logic                            ld_gpr3;
      logic [$clog2(`WB_NUM_GPR)-1:0]  dr3;
      logic [31:0]                     data3;
      datasize_e                       datasize;
      logic                            ld_eip;
      logic [31:0]                     eip;
      logic                            ld_cs;
      logic [15:0]                     cs;
   } commit_t;

endpackage

`default_nettype wire

/* wb_settings.svh */
// shared defines for register count and flag bit positions
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// general register file size, index width follows from it
`define WB_NUM_GPR 8

// bit positions inside the 32-bit flags word
`define WB_CF_BIT 0
`define WB_PF_BIT 2
`define WB_AF_BIT 4
`define WB_ZF_BIT 6
`define WB_SF_BIT 7
`define WB_DF_BIT 10
`define WB_OF_BIT 11

`endif

/* wb_stage.sv */
// writeback stage: uop register, flags, commit control and commit struct
`default_nettype none

module wb_stage (
   input  logic            CLK,
   input  logic            rst_n,
   input  wb_pkg::uop_t    uop_in,
   input  logic            st_done,
   output logic            stall,
   output wb_pkg::commit_t commit,
   output logic            st_req,
   output logic [31:0]     st_adr,
   output logic [31:0]     st_dat,
   output wb_pkg::flags_u  flags,
   output logic            halted,
   output logic            repne_term
);

   wb_pkg::uop_t cur;
   logic         accept;
   logic         retire;
   logic [31:0]  data1;

   logic v_ld_gpr1, v_ld_gpr2, v_ld_gpr3;
   logic v_ld_eip, v_ld_cs, v_ld_flags;
   logic v_pop, v_store, v_halt;

   wb_commit_ctrl u_commit_ctrl (
      .uop        (cur),
      .flags      (flags),
      .ld_gpr1    (v_ld_gpr1),
      .ld_gpr2    (v_ld_gpr2),
      .ld_gpr3    (v_ld_gpr3),
      .ld_eip     (v_ld_eip),
      .ld_cs      (v_ld_cs),
      .ld_flags   (v_ld_flags),
      .pop        (v_pop),
      .store      (v_store),
      .halt       (v_halt),
      .repne_term (repne_term)
   );

   wb_flags_reg u_flags_reg (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .upd       (retire & v_ld_flags),
      .pop       (retire & v_pop),
      .mask      (cur.flags_affected),
      .new_flags (cur.new_flags),
      .pop_word  (cur.result_a),
      .flags     (flags)
   );

   // a store waits for its ack, anything else leaves after one cycle
   assign retire = cur.valid & (~v_store | st_done);
   assign stall  = halted | v_halt | (v_store & ~st_done);
   assign accept = uop_in.valid & ~stall;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         cur.valid <= 1'b0;
      end else if (accept) begin
         cur <= uop_in;
      end else if (retire) begin
         cur.valid <= 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (retire && v_halt) begin
         halted <= 1'b1;
      end
   end

   // pushf writes the flags word instead of result_a
   assign data1 = cur.push_flags ? flags.raw : cur.result_a;

   assign st_req = v_store;
   assign st_adr = cur.address;
   assign st_dat = data1;

   always_comb begin
      commit.ld_gpr1  = retire & v_ld_gpr1;
      commit.dr1      = cur.dr1;
      commit.data1    = data1;
      commit.ld_gpr2  = retire & v_ld_gpr2;
      commit.dr2      = cur.dr2;
      commit.data2    = cur.result_b;
      commit.ld_gpr3  = retire & v_ld_gpr3;
      commit.dr3      = cur.dr3;
      commit.data3    = cur.result_c;
      commit.datasize = cur.datasize;
      commit.ld_eip   = retire & v_ld_eip;
      commit.eip      = cur.neip;
      commit.ld_cs    = retire & v_ld_cs;
      commit.cs       = cur.ncs;
   end

endmodule

`default_nettype wire

/* wb_store_port.sv */
// wishbone classic master doing one dword store per request
`default_nettype none

module wb_store_port (
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        st_req,
   input  logic [31:0] st_adr,
   input  logic [31:0] st_dat,
   output logic        st_done,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output logic [31:0] wb_adr,
   output logic [31:0] wb_dat_w,
   output logic [3:0]  wb_sel,
   input  logic        wb_ack
);

   logic busy;

   // idle/busy, always back to idle for a cycle after the ack
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         busy <= 1'b0;
      end else if (busy) begin
         if (wb_ack) begin
            busy <= 1'b0;
         end
      end else if (st_req) begin
         busy <= 1'b1;
      end
   end

   // address and data captured at the start of the cycle
   always_ff @(posedge CLK) begin
      if (!busy && st_req) begin
         wb_adr   <= st_adr;
         wb_dat_w <= st_dat;
      end
   end

   assign st_done = busy & wb_ack;
   assign wb_cyc  = busy;
   assign wb_stb  = busy;
   assign wb_we   = busy;
   // stores are always full dwords
   assign wb_sel  = 4'b1111;

endmodule

`default_nettype wire

/* wb_top.sv */
// writeback top: stage, wishbone store port and register file
`default_nettype none

`include "wb_settings.svh"

module wb_top (
   input  logic                           CLK,
   input  logic                           rst_n,
   input  wb_pkg::uop_t                   uop_in,
   output logic                           stall,
   output logic                           wb_cyc,
   output logic                           wb_stb,
   output logic                           wb_we,
   output logic [31:0]                    wb_adr,
   output logic [31:0]                    wb_dat_w,
   output logic [3:0]                     wb_sel,
   input  logic                           wb_ack,
   input  logic [$clog2(`WB_NUM_GPR)-1:0] rd_idx,
   output logic [31:0]                    rd_data,
   output logic [31:0]                    eip,
   output logic [15:0]                    cs,
   output wb_pkg::flags_u                 flags,
   output logic                           halted,
   output logic                           repne_term
);

   wb_pkg::commit_t commit;
   logic            st_req;
   logic [31:0]     st_adr;
   logic [31:0]     st_dat;
   logic            st_done;

   wb_stage u_wb_stage (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .uop_in     (uop_in),
      .st_done    (st_done),
      .stall      (stall),
      .commit     (commit),
      .st_req     (st_req),
      .st_adr     (st_adr),
      .st_dat     (st_dat),
      .flags      (flags),
      .halted     (halted),
      .repne_term (repne_term)
   );

   wb_store_port u_wb_store_port (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .st_req   (st_req),
      .st_adr   (st_adr),
      .st_dat   (st_dat),
      .st_done  (st_done),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_sel   (wb_sel),
      .wb_ack   (wb_ack)
   );

   gpr_file u_gpr_file (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .commit  (commit),
      .rd_idx  (rd_idx),
      .rd_data (rd_data),
      .eip     (eip),
      .cs      (cs)
   );

endmodule

`default_nettype wire
